//--- Makefile
TOP := tb_renkon

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f filelist.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir

//--- dv/renkon_chk.sv
`timescale 1ns/1ps

module renkon_chk (
  input logic clk,
  input logic xrst,
  input logic cfg_req,
  input logic cfg_ack,
  input logic in_ready,
  input logic out_valid,
  input logic busy
);

  int fail_cnt = 0;  // Read by the testbench at the end of the run.

  // Outputs settle low on the edge after a reset cycle.
  reset_state: assert property (@(posedge clk)
    !xrst |=> !cfg_ack && !in_ready && !out_valid && !busy)
    else begin
      fail_cnt++;
      $error("cfg_ack, in_ready, out_valid or busy high after reset");
    end

  ack_rise: assert property (@(posedge clk) disable iff (!xrst)
    $rose(cfg_ack) |-> $past(cfg_req))
    else begin
      fail_cnt++;
      $error("cfg_ack rose without a pending cfg_req");
    end

  ack_fall: assert property (@(posedge clk) disable iff (!xrst)
    $fell(cfg_ack) |-> !$past(cfg_req))
    else begin
      fail_cnt++;
      $error("cfg_ack fell while cfg_req was still high");
    end

  // Settled handshake holds until the request moves.
  ack_hold: assert property (@(posedge clk) disable iff (!xrst)
    (cfg_ack == cfg_req) |=> $stable(cfg_ack))
    else begin
      fail_cnt++;
      $error("cfg_ack changed while cfg_req held still");
    end

  out_in_run: assert property (@(posedge clk) disable iff (!xrst)
    out_valid |-> busy)
    else begin
      fail_cnt++;
      $error("out_valid high while busy is low");
    end

  ready_in_run: assert property (@(posedge clk) disable iff (!xrst)
    in_ready |-> busy)
    else begin
      fail_cnt++;
      $error("in_ready high while busy is low");
    end

endmodule

//--- dv/tb_renkon.sv
`timescale 1ns/1ps

module tb_renkon
  import renkon_pkg::*;
  import renkon_ctrl_pkg::*;
();

  logic                       clk;
  logic                       xrst;
  logic                       cfg_req;
  cfg_op_e                    cfg_op;
  logic [3:0]                 cfg_idx;
  logic [DWIDTH-1:0]          cfg_data;
  logic                       cfg_ack;
  logic                       in_valid;
  logic signed [DWIDTH-1:0]   in_data;
  logic                       in_ready;
  logic                       out_valid;
  logic signed [ACCWIDTH-1:0] out_data;
  logic                       busy;

  logic [7:0]                 lfsr;
  int                         err_cnt;
  logic signed [DWIDTH-1:0]   img [MAXIMG][MAXIMG];
  logic signed [DWIDTH-1:0]   wt [MAXFIL*MAXFIL];  // Weights the reference model uses.
  int                         exp_q [$];

  renkon_top UUT (
    .clk       (clk),
    .xrst      (xrst),
    .cfg_req   (cfg_req),
    .cfg_op    (cfg_op),
    .cfg_idx   (cfg_idx),
    .cfg_data  (cfg_data),
    .cfg_ack   (cfg_ack),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_data  (out_data),
    .busy      (busy)
  );

  bind renkon_top renkon_chk u_chk (
    .clk       (clk),
    .xrst      (xrst),
    .cfg_req   (cfg_req),
    .cfg_ack   (cfg_ack),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .busy      (busy)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // x^8 + x^6 + x^5 + x^4 + 1, shifting left.
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  function automatic int take_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v = (v << 1) | int'(lfsr[0]);
    end
    return v;
  endfunction

  // Zero-padded 3x3 correlation, tap index row*3+col.
  function automatic int ref_pixel(input int r, input int c, input int w, input int h);
    int acc;
    int y;
    int x;
    acc = 0;
    for (int i = 0; i < MAXFIL; i++) begin
      for (int j = 0; j < MAXFIL; j++) begin
        y = r + i - MAXPAD;
        x = c + j - MAXPAD;
        if (y >= 0 && y < h && x >= 0 && x < w) begin
          acc += int'(img[y][x]) * int'(wt[MAXFIL*i+j]);
        end
      end
    end
    return acc;
  endfunction

  // One four-phase transfer, fields held with the request.
  task automatic cfg_write(input cfg_op_e op, input logic [3:0] idx,
                           input logic [DWIDTH-1:0] data);
    @(posedge clk);
    cfg_req  <= 1'b1;
    cfg_op   <= op;
    cfg_idx  <= idx;
    cfg_data <= data;
    do @(negedge clk); while (!cfg_ack);
    @(posedge clk);
    cfg_req <= 1'b0;
    do @(negedge clk); while (cfg_ack);
  endtask

  task automatic new_weights();
    for (int i = 0; i < MAXFIL * MAXFIL; i++) begin
      wt[i] = DWIDTH'(take_bits(DWIDTH));
      cfg_write(CFG_WEIGHT, 4'(i), wt[i]);
    end
  endtask

  // Inverted weights sent mid-run, the locked registers must drop them.
  task automatic write_locked_weights();
    for (int i = 0; i < MAXFIL * MAXFIL; i++) begin
      assert (busy) else begin
        $display("Weight write %0d was issued after the run had ended", i);
        err_cnt++;
      end
      cfg_write(CFG_WEIGHT, 4'(i), ~wt[i]);
    end
  endtask

  task automatic fill_image(input int w, input int h);
    for (int r = 0; r < h; r++) begin
      for (int c = 0; c < w; c++) begin
        img[r][c] = DWIDTH'(take_bits(DWIDTH));
      end
    end
  endtask

  task automatic feed_image(input int w, input int h, input bit gaps);
    int gap;
    @(posedge clk);
    for (int r = 0; r < h; r++) begin
      for (int c = 0; c < w; c++) begin
        if (gaps) begin
          gap = take_bits(2);  // Zero to three idle cycles.
          in_valid <= 1'b0;
          repeat (gap) @(posedge clk);
        end
        in_valid <= 1'b1;
        in_data  <= img[r][c];
        do @(negedge clk); while (!in_ready);
        @(posedge clk);  // Pixel taken here.
      end
    end
    in_valid <= 1'b0;
  endtask

  task automatic collect(input string name, input int n);
    int got;
    int want;
    got = 0;
    do begin
      @(negedge clk);
      if (out_valid) begin
        if (exp_q.size() > 0) begin
          want = exp_q.pop_front();
          assert (int'(out_data) == want) else begin
            $display("ERR %s: result %0d expected %0d actual %0d",
                     name, got, want, out_data);
            err_cnt++;
          end
        end
        got++;
      end
    end while (busy);
    assert (got == n) else begin
      $display("ERR %s result count: expected %0d actual %0d", name, n, got);
      err_cnt++;
    end
    repeat (4) begin
      @(negedge clk);
      assert (!out_valid) else begin
        $display("%s: a result came out after busy fell", name);
        err_cnt++;
      end
    end
  endtask

  task automatic run_image(input string name, input int w, input int h,
                           input bit gaps, input bit locked_wr);
    exp_q.delete();
    for (int r = 0; r < h; r++) begin
      for (int c = 0; c < w; c++) begin
        exp_q.push_back(ref_pixel(r, c, w, h));
      end
    end
    cfg_write(CFG_WIDTH, 4'd0, DWIDTH'(w));
    cfg_write(CFG_HEIGHT, 4'd0, DWIDTH'(h));
    cfg_write(CFG_START, 4'd0, '0);
    fork
      feed_image(w, h, gaps);
      collect(name, w * h);
      if (locked_wr) write_locked_weights();
    join
  endtask

  initial begin
    lfsr     = 8'd89;
    err_cnt  = 0;
    xrst     = 1'b0;
    cfg_req  = 1'b0;
    cfg_op   = CFG_WIDTH;
    cfg_idx  = '0;
    cfg_data = '0;
    in_valid = 1'b0;
    in_data  = '0;
    repeat (2) @(posedge clk);
    xrst <= 1'b1;

    new_weights();
    fill_image(MAXIMG, MAXIMG);
    run_image("full_32x32", MAXIMG, MAXIMG, 1'b0, 1'b0);
    fill_image(5, 4);
    run_image("small_5x4", 5, 4, 1'b0, 1'b0);
    new_weights();
    fill_image(7, 6);
    run_image("stall_7x6", 7, 6, 1'b1, 1'b1);
    run_image("nostall_7x6", 7, 6, 1'b0, 1'b0);  // Same image, weights from before.

    $display("errors: scoreboard %0d, assertions %0d", err_cnt, UUT.u_chk.fail_cnt);
    if (err_cnt == 0 && UUT.u_chk.fail_cnt == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

  // All pixels at up to eight cycles each, plus slack for configuration.
  initial begin
    int pix;
    pix = 32 * 32 + 5 * 4 + 2 * 7 * 6;
    #((pix * 8 + 2000) * 40);
    $display("Watchdog expired before all runs finished");
    $display("sim failed");
    $finish;
  end

endmodule

//--- filelist.f
hdl/renkon_pkg.sv
hdl/renkon_ctrl_pkg.sv
hdl/mem_sp.sv
hdl/renkon_cfg.sv
hdl/renkon_sweep_ctrl.sv
hdl/renkon_linebuf_pad.sv
hdl/renkon_window_mac.sv
hdl/renkon_top.sv
dv/renkon_chk.sv
dv/tb_renkon.sv

//--- hdl/mem_sp.sv
`timescale 1ns/1ps

module mem_sp #(
  parameter int WIDTH      = 8,
  parameter int DEPTHWIDTH = 6
) (
  input  logic                  clk,
  input  logic                  mem_we,
  input  logic [DEPTHWIDTH-1:0] mem_addr,
  input  logic [WIDTH-1:0]      mem_wdata,
  output logic [WIDTH-1:0]      mem_rdata
);

  logic [WIDTH-1:0] mem [2**DEPTHWIDTH];

  // Read is registered every cycle, old data on a write.
  always_ff @(posedge clk) begin
    if (mem_we) begin
      mem[mem_addr] <= mem_wdata;
    end
    mem_rdata <= mem[mem_addr];
  end

endmodule

//--- hdl/renkon_cfg.sv
`timescale 1ns/1ps

module renkon_cfg
  import renkon_pkg::*;
  import renkon_ctrl_pkg::*;
(
  input  logic                     clk,
  input  logic                     xrst,
  input  logic                     cfg_req,
  input  cfg_op_e                  cfg_op,
  input  logic [3:0]               cfg_idx,
  input  logic [DWIDTH-1:0]        cfg_data,
  input  logic                     done,
  output logic                     cfg_ack,
  output logic [DIMWIDTH-1:0]      img_width,
  output logic [DIMWIDTH-1:0]      img_height,
  output logic signed [DWIDTH-1:0] weight [MAXFIL*MAXFIL],
  output logic                     start,
  output logic                     busy
);

  logic wr_stb;   // Edge on which ack rises.
  logic accept;   // Write allowed to land.

  assign wr_stb = cfg_req && !cfg_ack;
  assign accept = wr_stb && !busy;

  // Four-phase acknowledge simply follows the request by one cycle.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      cfg_ack <= 1'b0;
    end else begin
      cfg_ack <= cfg_req;
    end
  end

  // Start pulse and run flag.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      start <= 1'b0;
      busy  <= 1'b0;
    end else begin
      start <= accept && (cfg_op == CFG_START);
      if (accept && (cfg_op == CFG_START)) begin
        busy <= 1'b1;
      end else if (done) begin
        busy <= 1'b0;
      end
    end
  end

  // Image size defaults to the largest frame.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      img_width  <= DIMWIDTH'(MAXIMG);
      img_height <= DIMWIDTH'(MAXIMG);
    end else if (accept) begin
      if (cfg_op == CFG_WIDTH) begin
        img_width <= cfg_data[DIMWIDTH-1:0];
      end
      if (cfg_op == CFG_HEIGHT) begin
        img_height <= cfg_data[DIMWIDTH-1:0];
      end
    end
  end

  // Tap index is row*3+col, row 0 on top.
  always_ff @(posedge clk) begin
    if (accept && (cfg_op == CFG_WEIGHT) && (cfg_idx < MAXFIL * MAXFIL)) begin
      weight[cfg_idx] <= cfg_data;
    end
  end

endmodule

//--- hdl/renkon_ctrl_pkg.sv
package renkon_ctrl_pkg;

  // Configuration port commands.
  typedef enum logic [1:0] {
    CFG_WIDTH  = 2'd0,
    CFG_HEIGHT = 2'd1,
    CFG_WEIGHT = 2'd2,
    CFG_START  = 2'd3
  } cfg_op_e;

  // Sweep controller states.
  typedef enum logic [1:0] {
    ST_IDLE  = 2'd0,
    ST_SWEEP = 2'd1,
    ST_DRAIN = 2'd2
  } sweep_state_e;

endpackage

//--- hdl/renkon_linebuf_pad.sv
`timescale 1ns/1ps

module renkon_linebuf_pad
  import renkon_pkg::*;
(
  input  logic                     clk,
  input  logic                     xrst,
  input  logic                     buf_wcol,
  input  logic [MAXFIL-1:0]        buf_rrow,
  input  logic [LINEWIDTH-1:0]     buf_wsel,
  input  logic [LINEWIDTH-1:0]     buf_rsel,
  input  logic                     buf_we,
  input  logic [SIZEWIDTH-1:0]     buf_addr,
  input  logic                     buf_shift,
  input  logic signed [DWIDTH-1:0] buf_input,
  output logic signed [DWIDTH-1:0] buf_output [MAXFIL*MAXFIL]
);

  logic [BUFLINE-1:0]       line_we;
  logic signed [DWIDTH-1:0] line_wdata;
  logic signed [DWIDTH-1:0] line_rdata [BUFLINE];

  assign line_wdata = buf_wcol ? buf_input : '0;  // Pad columns store zero.

  for (genvar i = 0; i < BUFLINE; i++) begin : g_line
    assign line_we[i] = buf_we && (buf_wsel == LINEWIDTH'(i));

    mem_sp #(
      .WIDTH      (DWIDTH),
      .DEPTHWIDTH (SIZEWIDTH)
    ) u_mem (
      .clk       (clk),
      .mem_we    (line_we[i]),
      .mem_addr  (buf_addr),
      .mem_wdata (line_wdata),
      .mem_rdata (line_rdata[i])
    );
  end

  // One shift register per window row, newest column at the right.
  for (genvar i = 0; i < MAXFIL; i++) begin : g_row
    logic [LINEWIDTH-1:0]     sel;
    logic signed [DWIDTH-1:0] taps [MAXFIL];

    assign sel = buf_rsel + LINEWIDTH'(i);

    always_ff @(posedge clk) begin
      if (!xrst) begin
        for (int j = 0; j < MAXFIL; j++) begin
          taps[j] <= '0;
        end
      end else if (buf_shift) begin
        for (int j = 0; j < MAXFIL - 1; j++) begin
          taps[j] <= taps[j+1];
        end
        taps[MAXFIL-1] <= buf_rrow[i] ? line_rdata[sel] : '0;
      end
    end

    for (genvar j = 0; j < MAXFIL; j++) begin : g_tap
      assign buf_output[MAXFIL*i+j] = taps[j];
    end
  end

endmodule

//--- hdl/renkon_pkg.sv
package renkon_pkg;

  // Pixel and weight width, two's complement.
  localparam int DWIDTH = 8;

  // Filter and image geometry.
  localparam int MAXFIL = 3;
  localparam int MAXIMG = 32;
  localparam int MAXPAD = (MAXFIL - 1) / 2;

  // One spare line is written while the other three are read.
  localparam int BUFLINE = MAXFIL + 1;
  localparam int BUFSIZE = MAXIMG + 2 * MAXPAD; // Image columns plus pad columns.

  localparam int SIZEWIDTH = $clog2(BUFSIZE);
  localparam int LINEWIDTH = $clog2(BUFLINE);
  localparam int DIMWIDTH  = $clog2(MAXIMG + 1);

  // Full product plus 4 bits of growth for nine taps.
  localparam int ACCWIDTH = 2 * DWIDTH + 4;

endpackage

//--- hdl/renkon_sweep_ctrl.sv
`timescale 1ns/1ps

module renkon_sweep_ctrl
  import renkon_pkg::*;
  import renkon_ctrl_pkg::*;
(
  input  logic                 clk,
  input  logic                 xrst,
  input  logic                 start,
  input  logic [DIMWIDTH-1:0]  img_width,
  input  logic [DIMWIDTH-1:0]  img_height,
  input  logic                 in_valid,
  output logic                 in_ready,
  output logic                 buf_we,
  output logic                 buf_wcol,
  output logic [LINEWIDTH-1:0] buf_wsel,
  output logic [LINEWIDTH-1:0] buf_rsel,
  output logic [MAXFIL-1:0]    buf_rrow,
  output logic [SIZEWIDTH-1:0] buf_addr,
  output logic                 buf_shift,
  output logic                 win_valid,
  output logic                 done
);

  sweep_state_e         state;
  logic [DIMWIDTH-1:0]  sweep;      // Sweep index k.
  logic [SIZEWIDTH-1:0] col;        // Column address within the line.
  logic [1:0]           drain;
  logic [SIZEWIDTH-1:0] last_img_col;
  logic [SIZEWIDTH-1:0] last_col;
  logic [DIMWIDTH-1:0]  last_sweep;
  logic                 sweeping;
  logic                 pad_col;
  logic                 write_row;
  logic                 advance;
  logic                 win_cand;
  logic                 win_pre;
  logic [MAXFIL-1:0]    row_ok;

  assign last_img_col = SIZEWIDTH'(img_width) + SIZEWIDTH'(MAXPAD - 1);
  assign last_col     = SIZEWIDTH'(img_width) + SIZEWIDTH'(2 * MAXPAD - 1);
  assign last_sweep   = img_height + DIMWIDTH'(2 * MAXPAD - 1);

  assign sweeping  = (state == ST_SWEEP);
  assign pad_col   = (col < SIZEWIDTH'(MAXPAD)) || (col > last_img_col);
  assign write_row = (sweep < img_height);

  // Pad columns and read-only sweeps never wait for a pixel.
  assign advance  = sweeping && (pad_col || !write_row || in_valid);
  assign in_ready = sweeping && write_row && !pad_col;

  assign buf_we   = sweeping && write_row && advance;
  assign buf_wcol = !pad_col;
  assign buf_wsel = sweep[LINEWIDTH-1:0];   // Line k mod 4.
  assign buf_addr = col;

  // Centred window once three columns of a read sweep are in.
  assign win_cand = advance
                 && (sweep >= DIMWIDTH'(MAXFIL - 1))
                 && (col >= SIZEWIDTH'(MAXFIL - 1));

  // MAC result leaves two cycles after the last window.
  assign done = (state == ST_DRAIN) && (drain == 2'd2);

  // Window row i holds image row k-3+i, zero outside the frame.
  always_comb begin
    int row;
    for (int i = 0; i < MAXFIL; i++) begin
      row = int'(sweep) + i - MAXFIL;
      row_ok[i] = (row >= 0) && (row < int'(img_height));
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= ST_IDLE;
      sweep <= '0;
      col   <= '0;
      drain <= '0;
    end else begin
      case (state)
        ST_IDLE: begin
          if (start) begin
            state <= ST_SWEEP;
            sweep <= '0;
            col   <= '0;
          end
        end
        ST_SWEEP: begin
          if (advance) begin
            if (col == last_col) begin
              col <= '0;
              if (sweep == last_sweep) begin
                state <= ST_DRAIN;
                drain <= '0;
              end else begin
                sweep <= sweep + 1'b1;
              end
            end else begin
              col <= col + 1'b1;
            end
          end
        end
        ST_DRAIN: begin
          drain <= drain + 1'b1;
          if (done) begin
            state <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Read data lags the address by one cycle, so the read controls do too.
  always_ff @(posedge clk) begin
    if (!xrst) begin
      buf_shift <= 1'b0;
      buf_rsel  <= '0;
      buf_rrow  <= '0;
      win_pre   <= 1'b0;
      win_valid <= 1'b0;
    end else begin
      buf_shift <= advance;
      buf_rsel  <= sweep[LINEWIDTH-1:0] + LINEWIDTH'(BUFLINE - MAXFIL); // Oldest line.
      buf_rrow  <= row_ok;
      win_pre   <= win_cand;
      win_valid <= win_pre;   // Window register loads on the shift.
    end
  end

endmodule

//--- hdl/renkon_top.sv
`timescale 1ns/1ps

module renkon_top
  import renkon_pkg::*;
  import renkon_ctrl_pkg::*;
(
  input  logic                       clk,
  input  logic                       xrst,
  input  logic                       cfg_req,
  input  cfg_op_e                    cfg_op,
  input  logic [3:0]                 cfg_idx,
  input  logic [DWIDTH-1:0]          cfg_data,
  output logic                       cfg_ack,
  input  logic                       in_valid,
  input  logic signed [DWIDTH-1:0]   in_data,
  output logic                       in_ready,
  output logic                       out_valid,
  output logic signed [ACCWIDTH-1:0] out_data,
  output logic                       busy
);

  logic [DIMWIDTH-1:0]        img_width;
  logic [DIMWIDTH-1:0]        img_height;
  logic signed [DWIDTH-1:0]   weight [MAXFIL*MAXFIL];
  logic                       start;
  logic                       done;

  // Line buffer control from the sweep controller.
  logic                       buf_we;
  logic                       buf_wcol;
  logic [LINEWIDTH-1:0]       buf_wsel;
  logic [LINEWIDTH-1:0]       buf_rsel;
  logic [MAXFIL-1:0]          buf_rrow;
  logic [SIZEWIDTH-1:0]       buf_addr;
  logic                       buf_shift;
  logic                       win_valid;
  logic signed [DWIDTH-1:0]   buf_output [MAXFIL*MAXFIL];

  renkon_cfg u_cfg (
    .clk        (clk),
    .xrst       (xrst),
    .cfg_req    (cfg_req),
    .cfg_op     (cfg_op),
    .cfg_idx    (cfg_idx),
    .cfg_data   (cfg_data),
    .done       (done),
    .cfg_ack    (cfg_ack),
    .img_width  (img_width),
    .img_height (img_height),
    .weight     (weight),
    .start      (start),
    .busy       (busy)
  );

  renkon_sweep_ctrl u_ctrl (
    .clk        (clk),
    .xrst       (xrst),
    .start      (start),
    .img_width  (img_width),
    .img_height (img_height),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .buf_we     (buf_we),
    .buf_wcol   (buf_wcol),
    .buf_wsel   (buf_wsel),
    .buf_rsel   (buf_rsel),
    .buf_rrow   (buf_rrow),
    .buf_addr   (buf_addr),
    .buf_shift  (buf_shift),
    .win_valid  (win_valid),
    .done       (done)
  );

  renkon_linebuf_pad u_linebuf (
    .clk        (clk),
    .xrst       (xrst),
    .buf_wcol   (buf_wcol),
    .buf_rrow   (buf_rrow),
    .buf_wsel   (buf_wsel),
    .buf_rsel   (buf_rsel),
    .buf_we     (buf_we),
    .buf_addr   (buf_addr),
    .buf_shift  (buf_shift),
    .buf_input  (in_data),
    .buf_output (buf_output)
  );

  renkon_window_mac u_mac (
    .clk        (clk),
    .xrst       (xrst),
    .win_valid  (win_valid),
    .buf_output (buf_output),
    .weight     (weight),
    .out_valid  (out_valid),
    .out_data   (out_data)
  );

endmodule

//--- hdl/renkon_window_mac.sv
`timescale 1ns/1ps

module renkon_window_mac
  import renkon_pkg::*;
(
  input  logic                       clk,
  input  logic                       xrst,
  input  logic                       win_valid,
  input  logic signed [DWIDTH-1:0]   buf_output [MAXFIL*MAXFIL],
  input  logic signed [DWIDTH-1:0]   weight [MAXFIL*MAXFIL],
  output logic                       out_valid,
  output logic signed [ACCWIDTH-1:0] out_data
);

  logic signed [2*DWIDTH-1:0] prod [MAXFIL*MAXFIL];
  logic signed [ACCWIDTH-1:0] sum;

  for (genvar i = 0; i < MAXFIL * MAXFIL; i++) begin : g_tap
    assign prod[i] = buf_output[i] * weight[i];
  end

  // Nine-term adder tree, sign extended.
  always_comb begin
    sum = '0;
    for (int i = 0; i < MAXFIL * MAXFIL; i++) begin
      sum = sum + ACCWIDTH'(prod[i]);
    end
  end

  always_ff @(posedge clk) begin
    out_data <= sum;
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= win_valid;   // Matches the one-stage sum.
    end
  end

endmodule
